/* logic/pkt_sched_pkg.sv */
////////////////////////////////////////
// Shared types and limits for the packet scheduler
// Referenced by scoped names from the RTL and testbench
////////////////////////////////////////

package pkt_sched_pkg;

    ////////////////////////////////////////
    // Packet size limits in bytes
    ////////////////////////////////////////

    // Largest legal packet, one MTU
    parameter int max_pkt_bytes = 1500;

    // Smallest legal packet
    parameter int min_pkt_bytes = 64;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    // Byte count of a packet or of one word, wide enough for an MTU
    typedef logic [10:0] len_t;

    // Per-port scheduler state
    // port_idle  no packet selected, next pick goes by priority
    // port_busy  a queue is locked until its last word leaves
    typedef enum logic {
        port_idle = 1'b0,
        port_busy = 1'b1
    } port_state_e;

endpackage

/* logic/prio_scheduler.sv */
////////////////////////////////////////
// Strict-priority packet scheduler, one dequeue strobe per cycle
// Ports rotate round-robin, queues inside a port go by priority
////////////////////////////////////////

`timescale 1ns/1ns

module prio_scheduler #(
    parameter int num_ports       = 2,
    parameter int queues_per_port = 4
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic [num_ports*queues_per_port-1:0]            queue_empty,
    input  logic [num_ports-1:0]                            egr_ready,
    input  logic                                            word_valid,
    input  logic [$clog2(num_ports*queues_per_port)-1:0]    word_queue,
    input  logic                                            word_last,
    output logic                                            deq_valid,
    output logic [$clog2(num_ports*queues_per_port)-1:0]    deq_queue
);

    localparam int qw  = $clog2(num_ports * queues_per_port);
    localparam int pw  = (num_ports > 1) ? $clog2(num_ports) : 1;
    localparam int ppw = (queues_per_port > 1) ? $clog2(queues_per_port) : 1;

    pkt_sched_pkg::port_state_e state [num_ports];
    logic [ppw-1:0]             locked_prio [num_ports];
    logic [num_ports-1:0]       outstanding;
    logic [pw-1:0]              rr_ptr;

    logic [num_ports-1:0]       has_pkt;
    logic [ppw-1:0]             pick_prio [num_ports];
    logic [num_ports-1:0]       elig;
    logic [pw-1:0]              grant_port;
    logic                       found;
    logic [ppw-1:0]             sel_prio;
    logic [pw-1:0]              word_port;

    assign word_port = pw'(int'(word_queue) / queues_per_port);

    ////////////////////////////////////////
    // Candidate selection
    ////////////////////////////////////////

    // Highest non-empty priority of each port, later hits win
    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            has_pkt[p]   = 1'b0;
            pick_prio[p] = '0;
            for (int k = 0; k < queues_per_port; k++) begin
                if (!queue_empty[p*queues_per_port + k]) begin
                    has_pkt[p]   = 1'b1;
                    pick_prio[p] = ppw'(k);
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            elig[p] = egr_ready[p] && !outstanding[p] &&
                      (state[p] == pkt_sched_pkg::port_busy || has_pkt[p]);
        end
    end

    // Round-robin search starting at rr_ptr
    always_comb begin
        int p;
        found      = 1'b0;
        grant_port = '0;
        for (int i = 0; i < num_ports; i++) begin
            p = (int'(rr_ptr) + i) % num_ports;
            if (!found && elig[p]) begin
                found      = 1'b1;
                grant_port = pw'(p);
            end
        end
    end

    // A busy port keeps drawing from its locked queue
    assign sel_prio  = (state[grant_port] == pkt_sched_pkg::port_busy) ?
                       locked_prio[grant_port] : pick_prio[grant_port];
    assign deq_valid = found;
    assign deq_queue = qw'(int'(grant_port) * queues_per_port + int'(sel_prio));

    ////////////////////////////////////////
    // Port state
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < num_ports; p++) begin
                state[p] <= pkt_sched_pkg::port_idle;
            end
            outstanding <= '0;
            rr_ptr      <= '0;
        end else begin
            // Word back from the store frees the port
            if (word_valid) begin
                outstanding[word_port] <= 1'b0;
                if (word_last) begin
                    state[word_port] <= pkt_sched_pkg::port_idle;
                end
            end
            if (found) begin
                outstanding[grant_port] <= 1'b1;
                state[grant_port]       <= pkt_sched_pkg::port_busy;
                rr_ptr <= (grant_port == pw'(num_ports - 1)) ? '0 : grant_port + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            locked_prio[grant_port] <= sel_prio;
        end
    end

endmodule

/* logic/queue_store.sv */
////////////////////////////////////////
// Per-queue length FIFOs with a two-stage dequeue pipeline
// Each dequeue request yields one word two cycles later
////////////////////////////////////////

`timescale 1ns/1ns

module queue_store #(
    parameter int num_ports       = 2,
    parameter int queues_per_port = 4,
    parameter int word_bytes      = 64,
    parameter int fifo_depth      = 4
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            enq_valid,
    input  logic [$clog2(num_ports*queues_per_port)-1:0]    enq_queue,
    input  pkt_sched_pkg::len_t                             enq_len,
    output logic                                            enq_drop,
    input  logic                                            deq_valid,
    input  logic [$clog2(num_ports*queues_per_port)-1:0]    deq_queue,
    output logic [num_ports*queues_per_port-1:0]            queue_empty,
    output logic                                            word_valid,
    output logic [$clog2(num_ports*queues_per_port)-1:0]    word_queue,
    output pkt_sched_pkg::len_t                             word_bytes_out,
    output logic                                            word_last
);

    localparam int num_queues = num_ports * queues_per_port;
    localparam int qw = $clog2(num_queues);
    localparam int aw = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cw = $clog2(fifo_depth + 1);

    // Length storage and FIFO bookkeeping
    pkt_sched_pkg::len_t mem [num_queues][fifo_depth];
    logic [aw-1:0]       wr_ptr [num_queues];
    logic [aw-1:0]       rd_ptr [num_queues];
    logic [cw-1:0]       count [num_queues];
    // Bytes of the head packet already sent
    pkt_sched_pkg::len_t offset [num_queues];

    logic                len_legal;
    logic                target_full;
    logic                enq_ok;
    logic [num_queues-1:0] push_vec;
    logic [num_queues-1:0] pop_vec;

    logic                s1_valid;
    logic [qw-1:0]       s1_queue;
    pkt_sched_pkg::len_t s1_rem;
    logic                s1_last;

    function automatic logic [aw-1:0] ptr_next(input logic [aw-1:0] ptr);
        return (ptr == aw'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    ////////////////////////////////////////
    // Enqueue side
    ////////////////////////////////////////

    // Zero or oversized lengths cannot be segmented, drop them like a full queue
    assign len_legal   = (enq_len != '0) &&
                         (enq_len <= pkt_sched_pkg::len_t'(pkt_sched_pkg::max_pkt_bytes));
    assign target_full = (count[enq_queue] == cw'(fifo_depth));
    assign enq_ok      = enq_valid && len_legal && !target_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            enq_drop <= 1'b0;
        end else begin
            enq_drop <= enq_valid && !enq_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (enq_ok) begin
            mem[enq_queue][wr_ptr[enq_queue]] <= enq_len;
        end
    end

    always_comb begin
        for (int q = 0; q < num_queues; q++) begin
            push_vec[q] = enq_ok && (enq_queue == qw'(q));
            pop_vec[q]  = s1_valid && s1_last && (s1_queue == qw'(q));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int q = 0; q < num_queues; q++) begin
                wr_ptr[q] <= '0;
                rd_ptr[q] <= '0;
                count[q]  <= '0;
                offset[q] <= '0;
            end
        end else begin
            for (int q = 0; q < num_queues; q++) begin
                if (push_vec[q]) begin
                    wr_ptr[q] <= ptr_next(wr_ptr[q]);
                end
                // Final word pops the head, others advance the offset
                if (pop_vec[q]) begin
                    rd_ptr[q] <= ptr_next(rd_ptr[q]);
                    offset[q] <= '0;
                end else if (s1_valid && s1_queue == qw'(q)) begin
                    offset[q] <= offset[q] + pkt_sched_pkg::len_t'(word_bytes);
                end
                if (push_vec[q] && !pop_vec[q]) begin
                    count[q] <= count[q] + 1'b1;
                end else if (!push_vec[q] && pop_vec[q]) begin
                    count[q] <= count[q] - 1'b1;
                end
            end
        end
    end

    for (genvar q = 0; q < num_queues; q++) begin : g_empty
        assign queue_empty[q] = (count[q] == '0);
    end

    ////////////////////////////////////////
    // Dequeue pipeline
    ////////////////////////////////////////

    // Stage one: head length minus bytes already sent
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= deq_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_queue <= deq_queue;
        s1_rem   <= mem[deq_queue][rd_ptr[deq_queue]] - offset[deq_queue];
    end

    assign s1_last = (s1_rem <= pkt_sched_pkg::len_t'(word_bytes));

    // Stage two: emit a full word or the remainder
    always_ff @(posedge clk) begin
        if (rst) begin
            word_valid <= 1'b0;
            word_last  <= 1'b0;
        end else begin
            word_valid <= s1_valid;
            word_last  <= s1_valid && s1_last;
        end
    end

    always_ff @(posedge clk) begin
        word_queue     <= s1_queue;
        word_bytes_out <= s1_last ? s1_rem : pkt_sched_pkg::len_t'(word_bytes);
    end

endmodule

/* logic/egress_shaper.sv */
////////////////////////////////////////
// Per-port byte-rate shaper driving the egress ready levels
////////////////////////////////////////

`timescale 1ns/1ns

module egress_shaper #(
    parameter int num_ports       = 2,
    parameter int queues_per_port = 4,
    parameter int shape_rate      = 8,
    parameter int overhead_bytes  = 20
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            word_valid,
    input  logic [$clog2(num_ports*queues_per_port)-1:0]    word_queue,
    input  pkt_sched_pkg::len_t                             word_bytes_out,
    input  logic                                            word_last,
    output logic [num_ports-1:0]                            egr_ready
);

    localparam int pw = (num_ports > 1) ? $clog2(num_ports) : 1;

    // Two spare bits cover the sign and one word of overhead
    localparam int acc_w = $bits(pkt_sched_pkg::len_t) + 2;

    logic [pw-1:0] word_port;

    assign word_port = pw'(int'(word_queue) / queues_per_port);

    ////////////////////////////////////////
    // Leaky accumulators
    ////////////////////////////////////////

    for (genvar p = 0; p < num_ports; p++) begin : g_port

        logic signed [acc_w-1:0] acc;
        logic signed [acc_w-1:0] add_bytes;
        logic signed [acc_w-1:0] drain;

        // Bytes charged this cycle, framing overhead once per packet
        always_comb begin
            add_bytes = '0;
            if (word_valid && word_port == pw'(p)) begin
                add_bytes = signed'({2'b00, word_bytes_out});
                if (word_last) begin
                    add_bytes = add_bytes + acc_w'(overhead_bytes);
                end
            end
        end

        // Drain only while credit is owed
        assign drain = acc[acc_w-1] ? '0 : acc_w'(shape_rate);

        always_ff @(posedge clk) begin
            if (rst) begin
                // Start just below zero so the port is ready
                acc <= acc_w'(-1);
            end else begin
                acc <= acc + add_bytes - drain;
            end
        end

        // Negative accumulator means the port may take more data
        assign egr_ready[p] = acc[acc_w-1];

    end

endmodule

/* logic/pkt_sched_top.sv */
////////////////////////////////////////
// Top level of the packet dequeue scheduler
// Sets the parameters and wires scheduler, store and shaper
////////////////////////////////////////

`timescale 1ns/1ns

module pkt_sched_top #(
    parameter int num_ports       = 2,
    parameter int queues_per_port = 4,
    parameter int word_bytes      = 64,
    parameter int fifo_depth      = 4,
    parameter int shape_rate      = 8,
    parameter int overhead_bytes  = 20
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            enq_valid,
    input  logic [$clog2(num_ports*queues_per_port)-1:0]    enq_queue,
    input  pkt_sched_pkg::len_t                             enq_len,
    output logic                                            enq_drop,
    output logic                                            word_valid,
    output logic [$clog2(num_ports*queues_per_port)-1:0]    word_queue,
    output pkt_sched_pkg::len_t                             word_bytes_out,
    output logic                                            word_last
);

    localparam int num_queues = num_ports * queues_per_port;
    localparam int qw = $clog2(num_queues);

    logic [num_queues-1:0] queue_empty;
    logic [num_ports-1:0]  egr_ready;
    logic                  deq_valid;
    logic [qw-1:0]         deq_queue;

    ////////////////////////////////////////
    // Scheduler
    ////////////////////////////////////////

    prio_scheduler #(
        .num_ports       (num_ports),
        .queues_per_port (queues_per_port)
    ) u_sched (
        .clk         (clk),
        .rst         (rst),
        .queue_empty (queue_empty),
        .egr_ready   (egr_ready),
        .word_valid  (word_valid),
        .word_queue  (word_queue),
        .word_last   (word_last),
        .deq_valid   (deq_valid),
        .deq_queue   (deq_queue)
    );

    ////////////////////////////////////////
    // Queue store
    ////////////////////////////////////////

    queue_store #(
        .num_ports       (num_ports),
        .queues_per_port (queues_per_port),
        .word_bytes      (word_bytes),
        .fifo_depth      (fifo_depth)
    ) u_store (
        .clk            (clk),
        .rst            (rst),
        .enq_valid      (enq_valid),
        .enq_queue      (enq_queue),
        .enq_len        (enq_len),
        .enq_drop       (enq_drop),
        .deq_valid      (deq_valid),
        .deq_queue      (deq_queue),
        .queue_empty    (queue_empty),
        .word_valid     (word_valid),
        .word_queue     (word_queue),
        .word_bytes_out (word_bytes_out),
        .word_last      (word_last)
    );

    // Words also feed the shaper for rate accounting
    egress_shaper #(
        .num_ports       (num_ports),
        .queues_per_port (queues_per_port),
        .shape_rate      (shape_rate),
        .overhead_bytes  (overhead_bytes)
    ) u_shaper (
        .clk            (clk),
        .rst            (rst),
        .word_valid     (word_valid),
        .word_queue     (word_queue),
        .word_bytes_out (word_bytes_out),
        .word_last      (word_last),
        .egr_ready      (egr_ready)
    );

endmodule

/* testbench/pkt_sched_checker.sv */
////////////////////////////////////////
// Reference model and output checks for the scheduler
// Watches the top-level ports and counts errors
////////////////////////////////////////

`timescale 1ns/1ns

module pkt_sched_checker #(
    parameter int num_ports       = 2,
    parameter int queues_per_port = 4,
    parameter int word_bytes      = 64,
    parameter int shape_rate      = 8,
    parameter int overhead_bytes  = 20
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            enq_valid,
    input  logic [$clog2(num_ports*queues_per_port)-1:0]    enq_queue,
    input  pkt_sched_pkg::len_t                             enq_len,
    input  logic                                            exp_drop,
    input  logic                                            enq_drop,
    input  logic                                            word_valid,
    input  logic [$clog2(num_ports*queues_per_port)-1:0]    word_queue,
    input  pkt_sched_pkg::len_t                             word_bytes_out,
    input  logic                                            word_last,
    output int                                              error_count,
    output int                                              check_count,
    output int                                              pkt_count
);

    localparam int num_queues = num_ports * queues_per_port;

    // Accepted packet lengths per queue, head first
    int   model_q [num_queues][$];

    // Push seen this edge, resolved by enq_drop on the next one
    logic p1_valid;
    logic p1_exp;
    int   p1_queue;
    int   p1_len;
    // Two more stages so the model matches what the scheduler saw
    logic d1_valid;
    int   d1_queue;
    int   d1_len;
    logic d2_valid;
    int   d2_queue;
    int   d2_len;

    logic seen_enq;
    int   cyc;

    // Per-port packet in progress
    logic busy [num_ports];
    int   cur_q [num_ports];
    int   rem [num_ports];
    int   first_cyc [num_ports];
    int   prev_len [num_ports];
    logic have_prev [num_ports];

    function automatic int top_queue(input int port);
        int found;
        found = -1;
        // Higher index is higher priority, last hit wins
        for (int k = 0; k < queues_per_port; k++) begin
            if (model_q[port*queues_per_port + k].size() != 0) begin
                found = port * queues_per_port + k;
            end
        end
        return found;
    endfunction

    task automatic check_value(input string name, input int expected, input int got);
        check_count++;
        if (expected != got) begin
            error_count++;
            $display("[FAIL] %s: expected %0h, got %0h at cycle %0d", name, expected, got, cyc);
        end
    endtask

    ////////////////////////////////////////
    // Sampling and comparison
    ////////////////////////////////////////

    always @(posedge clk) begin
        int   port;
        int   exp_q;
        int   exp_bytes;
        logic exp_last;
        int   min_gap;
        if (rst) begin
            p1_valid    = 1'b0;
            d1_valid    = 1'b0;
            d2_valid    = 1'b0;
            seen_enq    = 1'b0;
            cyc         = 0;
            error_count = 0;
            check_count = 0;
            pkt_count   = 0;
            for (int p = 0; p < num_ports; p++) begin
                busy[p]      = 1'b0;
                have_prev[p] = 1'b0;
            end
        end else begin
            cyc++;
            // Quiet outputs until traffic starts
            if (!seen_enq) begin
                check_value("word_valid", 0, int'(word_valid));
                check_value("word_last", 0, int'(word_last));
            end
            check_value("enq_drop", int'(p1_valid && p1_exp), int'(enq_drop));

            if (d2_valid) begin
                model_q[d2_queue].push_back(d2_len);
            end
            d2_valid = d1_valid;
            d2_queue = d1_queue;
            d2_len   = d1_len;
            d1_valid = p1_valid && !enq_drop;
            d1_queue = p1_queue;
            d1_len   = p1_len;
            p1_valid = enq_valid;
            p1_exp   = exp_drop;
            p1_queue = int'(enq_queue);
            p1_len   = int'(enq_len);
            if (enq_valid) begin
                seen_enq = 1'b1;
            end

            if (word_valid) begin
                port = int'(word_queue) / queues_per_port;
                // New packet must come from the highest non-empty queue
                if (!busy[port]) begin
                    exp_q = top_queue(port);
                    if (exp_q < 0) begin
                        error_count++;
                        $display("Unexpected word on queue %0d, no packet waiting on port %0d",
                                 word_queue, port);
                    end else begin
                        // Spacing measured from the previous packet's first word
                        if (have_prev[port]) begin
                            min_gap = (prev_len[port] + overhead_bytes) / shape_rate;
                            check_count++;
                            if (cyc - first_cyc[port] < min_gap) begin
                                error_count++;
                                $display("Port %0d sent a packet %0d cycles after the last one, %s %0d",
                                         port, cyc - first_cyc[port], "shaping needs", min_gap);
                            end
                        end
                        first_cyc[port] = cyc;
                        busy[port]      = 1'b1;
                        cur_q[port]     = exp_q;
                        rem[port]       = model_q[exp_q][0];
                    end
                end
                if (busy[port]) begin
                    exp_last  = (rem[port] <= word_bytes);
                    exp_bytes = exp_last ? rem[port] : word_bytes;
                    check_value("word_queue", cur_q[port], int'(word_queue));
                    check_value("word_bytes_out", exp_bytes, int'(word_bytes_out));
                    check_value("word_last", int'(exp_last), int'(word_last));
                    rem[port] = rem[port] - exp_bytes;
                    if (exp_last) begin
                        prev_len[port]  = model_q[cur_q[port]].pop_front();
                        have_prev[port] = 1'b1;
                        busy[port]      = 1'b0;
                        pkt_count++;
                    end
                end
            end
        end
    end

endmodule

/* testbench/pkt_sched_sva.sv */
////////////////////////////////////////
// Protocol assertions, bound into the top level
////////////////////////////////////////

`timescale 1ns/1ns

module pkt_sched_sva #(
    parameter int num_ports       = 2,
    parameter int queues_per_port = 4,
    parameter int word_bytes      = 64
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            deq_valid,
    input  logic [$clog2(num_ports*queues_per_port)-1:0]    deq_queue,
    input  logic [num_ports*queues_per_port-1:0]            queue_empty,
    input  logic                                            word_valid,
    input  logic [$clog2(num_ports*queues_per_port)-1:0]    word_queue,
    input  pkt_sched_pkg::len_t                             word_bytes_out,
    input  logic                                            word_last
);

    localparam int pw = (num_ports > 1) ? $clog2(num_ports) : 1;

    logic [pw-1:0]        deq_port;
    logic [pw-1:0]        word_port;
    // Port has a packet in flight
    logic [num_ports-1:0] busy;

    assign deq_port  = pw'(int'(deq_queue) / queues_per_port);
    assign word_port = pw'(int'(word_queue) / queues_per_port);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (word_valid && word_last) begin
                busy[word_port] <= 1'b0;
            end
            if (deq_valid) begin
                busy[deq_port] <= 1'b1;
            end
        end
    end

    a_deq_target: assert property (@(posedge clk) disable iff (rst)
        deq_valid |-> (!queue_empty[deq_queue] || busy[deq_port]))
        else $error("dequeue request on an empty queue of an idle port");

    a_word_follows: assert property (@(posedge clk) disable iff (rst)
        deq_valid |-> ##2 word_valid)
        else $error("no word two cycles after a dequeue request");

    a_word_source: assert property (@(posedge clk) disable iff (rst)
        word_valid |-> $past(deq_valid, 2))
        else $error("word without a request two cycles earlier");

    a_word_size: assert property (@(posedge clk) disable iff (rst)
        word_valid |-> (word_bytes_out != '0 &&
                        word_bytes_out <= pkt_sched_pkg::len_t'(word_bytes)))
        else $error("word byte count out of range");

endmodule

bind pkt_sched_top pkt_sched_sva #(
    .num_ports       (num_ports),
    .queues_per_port (queues_per_port),
    .word_bytes      (word_bytes)
) sva_i (
    .clk            (clk),
    .rst            (rst),
    .deq_valid      (deq_valid),
    .deq_queue      (deq_queue),
    .queue_empty    (queue_empty),
    .word_valid     (word_valid),
    .word_queue     (word_queue),
    .word_bytes_out (word_bytes_out),
    .word_last      (word_last)
);

/* testbench/pkt_sched_tb.sv */
////////////////////////////////////////
// Testbench top that drives the enqueue table into the DUT
// A checker instance compares the outputs against a model
////////////////////////////////////////

`timescale 1ns/1ns

module pkt_sched_tb;

    localparam int num_ports       = 2;
    localparam int queues_per_port = 4;
    localparam int word_bytes      = 64;
    localparam int fifo_depth      = 4;
    localparam int shape_rate      = 8;
    localparam int overhead_bytes  = 20;
    localparam int qw              = $clog2(num_ports * queues_per_port);
    localparam int num_entries     = 22;
    localparam int max_len         = pkt_sched_pkg::max_pkt_bytes;
    localparam int min_len         = pkt_sched_pkg::min_pkt_bytes;

    typedef struct packed {
        int   queue;
        int   len;
        logic drop;
    } stim_t;

    ////////////////////////////////////////
    // Stimulus table of queue, length and expected drop
    ////////////////////////////////////////

    // Queue 3 first and back to back so its fifth push finds it full
    // Long low-priority packet opens port 1 so later arrivals test the queue lock
    stim_t stim [num_entries] = '{
        '{3, max_len, 1'b0}, '{3, 256, 1'b0},  '{3, 600, 1'b0},  '{3, 128, 1'b0},
        '{3, 900, 1'b1},     '{4, 1024, 1'b0}, '{0, min_len, 1'b0}, '{5, 65, 1'b0},
        '{1, 300, 1'b0},     '{6, 128, 1'b0},  '{2, 1000, 1'b0}, '{7, max_len, 1'b0},
        '{0, 200, 1'b0},     '{5, 700, 1'b0},  '{1, min_len, 1'b0}, '{6, 65, 1'b0},
        '{2, 77, 1'b0},      '{7, 256, 1'b0},  '{0, 100, 1'b0},  '{4, min_len, 1'b0},
        '{1, 512, 1'b0},     '{2, min_len, 1'b0}
    };

    logic                core_clk_ifc = 1'b0;
    logic                rst;
    logic                enq_valid;
    logic [qw-1:0]       enq_queue;
    pkt_sched_pkg::len_t enq_len;
    logic                exp_drop;
    logic                enq_drop;
    logic                word_valid;
    logic [qw-1:0]       word_queue;
    pkt_sched_pkg::len_t word_bytes_out;
    logic                word_last;
    int                  error_count;
    int                  check_count;
    int                  pkt_count;

    always #20 core_clk_ifc = ~core_clk_ifc;

    pkt_sched_top #(
        .num_ports       (num_ports),
        .queues_per_port (queues_per_port),
        .word_bytes      (word_bytes),
        .fifo_depth      (fifo_depth),
        .shape_rate      (shape_rate),
        .overhead_bytes  (overhead_bytes)
    ) dut_i (
        .clk            (core_clk_ifc),
        .rst            (rst),
        .enq_valid      (enq_valid),
        .enq_queue      (enq_queue),
        .enq_len        (enq_len),
        .enq_drop       (enq_drop),
        .word_valid     (word_valid),
        .word_queue     (word_queue),
        .word_bytes_out (word_bytes_out),
        .word_last      (word_last)
    );

    pkt_sched_checker #(
        .num_ports       (num_ports),
        .queues_per_port (queues_per_port),
        .word_bytes      (word_bytes),
        .shape_rate      (shape_rate),
        .overhead_bytes  (overhead_bytes)
    ) checker_i (
        .clk            (core_clk_ifc),
        .rst            (rst),
        .enq_valid      (enq_valid),
        .enq_queue      (enq_queue),
        .enq_len        (enq_len),
        .exp_drop       (exp_drop),
        .enq_drop       (enq_drop),
        .word_valid     (word_valid),
        .word_queue     (word_queue),
        .word_bytes_out (word_bytes_out),
        .word_last      (word_last),
        .error_count    (error_count),
        .check_count    (check_count),
        .pkt_count      (pkt_count)
    );

    initial begin
        int limit;
        int exp_pkts;
        int words;
        int cycles;
        bit timed_out;
        rst       = 1'b1;
        enq_valid = 1'b0;
        enq_queue = '0;
        enq_len   = '0;
        exp_drop  = 1'b0;
        cycles    = 0;

        // Cycle budget per packet from words and shaping time
        limit    = 200;
        exp_pkts = 0;
        foreach (stim[i]) begin
            words = (stim[i].len + word_bytes - 1) / word_bytes;
            limit = limit + words + (stim[i].len + overhead_bytes) / shape_rate + 1;
            if (!stim[i].drop) begin
                exp_pkts++;
            end
        end

        repeat (3) @(posedge core_clk_ifc);
        #1;
        rst = 1'b0;

        for (int i = 0; i < num_entries; i++) begin
            @(posedge core_clk_ifc);
            #1;
            enq_valid = 1'b1;
            enq_queue = qw'(stim[i].queue);
            enq_len   = pkt_sched_pkg::len_t'(stim[i].len);
            exp_drop  = stim[i].drop;
        end
        @(posedge core_clk_ifc);
        #1;
        enq_valid = 1'b0;
        exp_drop  = 1'b0;

        while (pkt_count < exp_pkts && cycles < limit) begin
            @(posedge core_clk_ifc);
            #1;
            cycles++;
        end
        timed_out = (pkt_count < exp_pkts);

        if (timed_out) begin
            $display("Timeout after %0d cycles with packets still queued", limit);
        end else begin
            // Idle tail catches any stray word
            repeat (30) @(posedge core_clk_ifc);
            #1;
        end

        $display("Checks: %0d, errors: %0d, packets: %0d of %0d",
                 check_count, error_count, pkt_count, exp_pkts);
        if (timed_out || error_count != 0) begin
            $display("FAIL: see errors above");
        end else begin
            $display("PASS: all tests");
        end
        $finish;
    end

endmodule

/* pkt_sched.f */
logic/pkt_sched_pkg.sv
logic/prio_scheduler.sv
logic/queue_store.sv
logic/egress_shaper.sv
logic/pkt_sched_top.sv
testbench/pkt_sched_checker.sv
testbench/pkt_sched_sva.sv
testbench/pkt_sched_tb.sv

/* Makefile */
# Verilator build and run for the packet scheduler testbench

VERILATOR ?= verilator
TOP       ?= pkt_sched_tb
FILELIST  ?= pkt_sched.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	elif ! grep -q "PASS: all tests" $(LOG); then \
		echo "Simulation stopped without a verdict"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
